// File: hdl/decode_pkg.sv
/*
 * Shared definitions for the decode stage: widths, major opcodes,
 * unit and operation encodings, fetch and decoded record structs
 */
package decode_pkg;

    localparam int xlen          = 32;
    localparam int num_threads   = 4;
    localparam int nw_bits       = 2;
    localparam int nr_bits       = 5;
    localparam int op_bits       = 4;
    localparam int mod_bits      = 3;
    localparam int csr_addr_bits = 12;

    typedef enum logic [1:0] {
        alu = 2'd0,
        lsu = 2'd1,
        sfu = 2'd2
    } ex_type_e;

    // RV32 major opcodes plus custom-0 as ext1
    typedef enum logic [6:0] {
        op_imm = 7'b0010011,
        op     = 7'b0110011,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        branch = 7'b1100011,
        load   = 7'b0000011,
        store  = 7'b0100011,
        fence  = 7'b0001111,
        system = 7'b1110011,
        ext1   = 7'b0001011
    } opcode_e;

    typedef enum logic [op_bits-1:0] {
        add = 4'b0000, lui_op = 4'b0010, auipc_op = 4'b0011, sltu = 4'b0100,
        slt = 4'b0101, srl = 4'b1000, sra = 4'b1001, sub = 4'b1011,
        and_op = 4'b1100, or_op = 4'b1101, xor_op = 4'b1110, sll = 4'b1111
    } alu_op_e;

    typedef enum logic [op_bits-1:0] {
        eq = 4'b0000, ne = 4'b0010, ltu = 4'b0100, lt = 4'b0101,
        geu = 4'b0110, ge = 4'b0111, jal_op = 4'b1000, jalr_op = 4'b1001,
        ecall = 4'b1010, ebreak = 4'b1011, uret = 4'b1100, sret = 4'b1101,
        mret = 4'b1110
    } br_op_e;

    typedef enum logic [op_bits-1:0] {
        mul, mulh, mulhsu, mulhu, div, divu, rem, remu
    } mul_op_e;

    // join_op avoids the join keyword
    typedef enum logic [op_bits-1:0] {
        tmc, wspawn, split, join_op, bar, pred, csrrw, csrrs, csrrc
    } sfu_op_e;

    localparam logic [op_bits-1:0] lsu_fence = 4'b1111;

    typedef struct packed {
        logic [nw_bits-1:0]     wid;
        logic [num_threads-1:0] tmask;
        logic [xlen-1:0]        pc;
        logic [31:0]            instr;
    } fetch_t;

    typedef struct packed {
        logic [nw_bits-1:0]     wid;
        logic [num_threads-1:0] tmask;
        logic [xlen-1:0]        pc;
        ex_type_e               ex_type;
        logic [op_bits-1:0]     op_type;
        logic [mod_bits-1:0]    op_mod;   // 0 branch/jump, 1 mul/div
        logic                   use_pc;
        logic [xlen-1:0]        imm;
        logic                   use_imm;
        logic                   wb;
        logic [nr_bits-1:0]     rd;
        logic [nr_bits-1:0]     rs1;
        logic [nr_bits-1:0]     rs2;
    } decoded_t;

    typedef struct packed {
        logic [xlen-1:0] i_imm;
        logic [xlen-1:0] s_imm;
        logic [xlen-1:0] b_imm;
        logic [xlen-1:0] u_imm;
        logic [xlen-1:0] j_imm;
        logic [xlen-1:0] csr_imm;
    } imm_set_t;

    typedef struct packed {
        logic [op_bits-1:0] r_op;
        logic [op_bits-1:0] b_op;
        logic [op_bits-1:0] m_op;
        logic [op_bits-1:0] s_op;
    } func_ops_t;

endpackage

// File: hdl/imm_gen.sv
/*
 * Immediate generator: sign-extended I, S, B, U and J immediates
 * plus the packed CSR address / uimm value
 */
module imm_gen (
    input  logic [31:0]           instr,
    output decode_pkg::imm_set_t imms
);

    localparam int xlen = decode_pkg::xlen;

    logic [2:0]  funct3;
    logic [11:0] imm12;
    logic [11:0] s12;
    logic [12:0] b13;
    logic [20:0] j21;
    logic [decode_pkg::nr_bits-1:0] uimm;
    logic        is_shift;

    assign funct3 = instr[14:12];
    assign imm12  = instr[31:20];
    assign s12    = {instr[31:25], instr[11:7]};
    assign b13    = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j21    = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // SLLI, SRLI, SRAI carry a shamt, not a signed value
    assign is_shift = (instr[6:0] == decode_pkg::op_imm) && funct3[0] && !funct3[1];

    // Immediate CSR forms reuse the rs1 field
    assign uimm = funct3[2] ? instr[19:15] : '0;

    always_comb begin
        if (is_shift) begin
            imms.i_imm = {{(xlen-5){1'b0}}, instr[24:20]};
        end else begin
            imms.i_imm = {{(xlen-12){imm12[11]}}, imm12};
        end
        imms.s_imm   = {{(xlen-12){s12[11]}}, s12};
        imms.b_imm   = {{(xlen-13){b13[12]}}, b13};
        imms.u_imm   = {instr[31:12], 12'b0};
        imms.j_imm   = {{(xlen-21){j21[20]}}, j21};
        imms.csr_imm = {
            {(xlen - decode_pkg::csr_addr_bits - decode_pkg::nr_bits){1'b0}},
            uimm,
            imm12
        };
    end

endmodule

// File: hdl/func_decode.sv
/*
 * Function field decode: ALU, branch compare, mul/div and
 * environment call operation codes
 */
module func_decode (
    input  logic [31:0]            instr,
    output decode_pkg::func_ops_t ops
);

    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] sys_field;

    assign funct3    = instr[14:12];
    assign funct7    = instr[31:25];
    assign sys_field = instr[31:20];

    always_comb begin
        case (funct3)
            3'h0: ops.r_op = (instr[5] && funct7[5]) ? decode_pkg::sub : decode_pkg::add;
            3'h1: ops.r_op = decode_pkg::sll;
            3'h2: ops.r_op = decode_pkg::slt;
            3'h3: ops.r_op = decode_pkg::sltu;
            3'h4: ops.r_op = decode_pkg::xor_op;
            3'h5: ops.r_op = funct7[5] ? decode_pkg::sra : decode_pkg::srl;
            3'h6: ops.r_op = decode_pkg::or_op;
            default: ops.r_op = decode_pkg::and_op;
        endcase
    end

    always_comb begin
        case (funct3)
            3'h0: ops.b_op = decode_pkg::eq;
            3'h1: ops.b_op = decode_pkg::ne;
            3'h4: ops.b_op = decode_pkg::lt;
            3'h5: ops.b_op = decode_pkg::ge;
            3'h6: ops.b_op = decode_pkg::ltu;
            3'h7: ops.b_op = decode_pkg::geu;
            default: ops.b_op = '0;   // Reserved funct3
        endcase
    end

    // M extension follows funct3 order directly
    assign ops.m_op = {1'b0, funct3};

    always_comb begin
        case (sys_field)
            12'h000: ops.s_op = decode_pkg::ecall;
            12'h001: ops.s_op = decode_pkg::ebreak;
            12'h002: ops.s_op = decode_pkg::uret;
            12'h102: ops.s_op = decode_pkg::sret;
            12'h302: ops.s_op = decode_pkg::mret;
            default: ops.s_op = '0;
        endcase
    end

endmodule

// File: hdl/instr_decode.sv
/*
 * Control decode by major opcode: unit, operation, modifier,
 * register usage, immediate select and warp stall flag
 */
module instr_decode (
    input  decode_pkg::fetch_t    fetch,
    input  decode_pkg::imm_set_t  imms,
    input  decode_pkg::func_ops_t ops,
    output decode_pkg::decoded_t  dec,
    output logic                  wstall
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [decode_pkg::nr_bits-1:0] f_rd, f_rs1, f_rs2;
    logic use_rd;

    assign opcode = fetch.instr[6:0];
    assign funct3 = fetch.instr[14:12];
    assign funct7 = fetch.instr[31:25];
    assign f_rd   = fetch.instr[11:7];
    assign f_rs1  = fetch.instr[19:15];
    assign f_rs2  = fetch.instr[24:20];

    always_comb begin
        dec       = '0;
        use_rd    = 1'b0;
        wstall    = 1'b0;
        dec.wid   = fetch.wid;
        dec.tmask = fetch.tmask;
        dec.pc    = fetch.pc;

        case (opcode)
            decode_pkg::op_imm: begin
                dec.op_type = ops.r_op;
                {use_rd, dec.use_imm, dec.imm} = {2'b11, imms.i_imm};
                {dec.rd, dec.rs1} = {f_rd, f_rs1};
            end
            decode_pkg::op: begin
                if (funct7[0]) begin   // M extension
                    dec.op_type = ops.m_op;
                    dec.op_mod[1] = 1'b1;
                end else begin
                    dec.op_type = ops.r_op;
                end
                use_rd = 1'b1;
                {dec.rd, dec.rs1, dec.rs2} = {f_rd, f_rs1, f_rs2};
            end
            decode_pkg::lui, decode_pkg::auipc: begin
                dec.op_type = opcode[5] ? decode_pkg::lui_op : decode_pkg::auipc_op;
                dec.use_pc  = !opcode[5];
                {use_rd, dec.use_imm, dec.imm} = {2'b11, imms.u_imm};
                dec.rd = f_rd;
            end
            decode_pkg::jal: begin
                dec.op_type = decode_pkg::jal_op;
                {dec.op_mod[0], dec.use_pc, wstall} = 3'b111;
                {use_rd, dec.use_imm, dec.imm} = {2'b11, imms.j_imm};
                dec.rd = f_rd;
            end
            decode_pkg::jalr: begin
                dec.op_type = decode_pkg::jalr_op;
                {dec.op_mod[0], wstall} = 2'b11;
                {use_rd, dec.use_imm, dec.imm} = {2'b11, imms.i_imm};
                {dec.rd, dec.rs1} = {f_rd, f_rs1};
            end
            decode_pkg::branch: begin
                dec.op_type = ops.b_op;
                {dec.op_mod[0], dec.use_pc, wstall} = 3'b111;
                {dec.use_imm, dec.imm} = {1'b1, imms.b_imm};
                {dec.rs1, dec.rs2} = {f_rs1, f_rs2};
            end
            decode_pkg::load: begin
                dec.ex_type = decode_pkg::lsu;
                dec.op_type = {1'b0, funct3};
                {use_rd, dec.use_imm, dec.imm} = {2'b11, imms.i_imm};
                {dec.rd, dec.rs1} = {f_rd, f_rs1};
            end
            decode_pkg::store: begin
                dec.ex_type = decode_pkg::lsu;
                dec.op_type = {1'b1, funct3};
                {dec.use_imm, dec.imm} = {1'b1, imms.s_imm};
                {dec.rs1, dec.rs2} = {f_rs1, f_rs2};
            end
            decode_pkg::fence: begin
                dec.ex_type = decode_pkg::lsu;
                dec.op_type = decode_pkg::lsu_fence;
            end
            decode_pkg::system: begin
                wstall = 1'b1;
                use_rd = 1'b1;
                dec.rd = f_rd;
                if (funct3[1:0] != 2'b00) begin   // CSR access
                    dec.ex_type = decode_pkg::sfu;
                    dec.op_type = decode_pkg::csrrw + funct3[1:0] - 2'd1;
                    dec.use_imm = funct3[2];
                    dec.imm     = imms.csr_imm;
                    if (!funct3[2]) dec.rs1 = f_rs1;
                end else begin   // Returns to pc + 4
                    dec.op_type = ops.s_op;
                    {dec.op_mod[0], dec.use_pc, dec.use_imm} = 3'b111;
                    dec.imm = decode_pkg::xlen'(4);
                end
            end
            decode_pkg::ext1: begin
                if (funct7 == 7'h00) begin
                    dec.ex_type = decode_pkg::sfu;
                    wstall = 1'b1;
                    case (funct3)
                        3'h0, 3'h3: dec.rs1 = f_rs1;   // TMC, JOIN
                        3'h1, 3'h4, 3'h5: {dec.rs1, dec.rs2} = {f_rs1, f_rs2};
                        3'h2: {use_rd, dec.rd, dec.rs1} = {1'b1, f_rd, f_rs1};   // SPLIT
                        default: ;
                    endcase
                    if (funct3 <= 3'h5) dec.op_type = {1'b0, funct3};
                end
            end
            default: ;
        endcase

        dec.wb = use_rd && (dec.rd != '0);   // x0 never written
    end

endmodule

// File: hdl/decode_buffer.sv
/*
 * Single-entry valid/ready output register for decoded records,
 * one record per cycle at full throughput
 */
module decode_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  decode_pkg::decoded_t in_data,
    output logic                 in_ready,
    output logic                 out_valid,
    output decode_pkg::decoded_t out_data,
    input  logic                 out_ready
);

    logic full;

    // Free when empty or draining this cycle
    assign in_ready  = !full || out_ready;
    assign out_valid = full;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;   // Refill or go empty
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

// File: hdl/decode_stage.sv
/*
 * Decode stage top: immediate and function decoders, control decode,
 * output register and scheduler stall strobe
 */
module decode_stage (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           fetch_valid,
    input  decode_pkg::fetch_t             fetch_data,
    output logic                           fetch_ready,
    output logic                           dec_valid,
    output decode_pkg::decoded_t           dec_data,
    input  logic                           dec_ready,
    output logic                           sched_valid,
    output logic [decode_pkg::nw_bits-1:0] sched_wid,
    output logic                           sched_stall
);

    decode_pkg::imm_set_t  imms;
    decode_pkg::func_ops_t ops;
    decode_pkg::decoded_t  dec_comb;

    imm_gen u_imm_gen (.instr(fetch_data.instr), .imms(imms));

    func_decode u_func_decode (.instr(fetch_data.instr), .ops(ops));

    instr_decode u_instr_decode (
        .fetch  (fetch_data),
        .imms   (imms),
        .ops    (ops),
        .dec    (dec_comb),
        .wstall (sched_stall)
    );

    decode_buffer u_decode_buffer (
        .clk(clk), .rst(rst),
        .in_valid(fetch_valid), .in_data(dec_comb), .in_ready(fetch_ready),
        .out_valid(dec_valid), .out_data(dec_data), .out_ready(dec_ready)
    );

    assign sched_valid = fetch_valid && fetch_ready;   // Strobe on transfer
    assign sched_wid   = fetch_data.wid;

endmodule

// File: test/decode_assertions.sv
/*
 * Concurrent checks on the decode stage output handshake,
 * reset state and scheduler strobe, bound to decode_stage
 */
module decode_assertions (
    input logic                 clk,
    input logic                 rst,
    input logic                 dec_valid,
    input decode_pkg::decoded_t dec_data,
    input logic                 dec_ready,
    input logic                 sched_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // Stalled output must not move
    a_hold: assert property (@(posedge clk) disable iff (rst)
        (dec_valid && !dec_ready) |=> (dec_valid && $stable(dec_data)))
        else begin
            fail_count++;
            $error("dec_valid or dec_data changed while dec_ready was low");
        end

    a_reset: assert property (@(posedge clk) rst |=> !dec_valid)
        else begin
            fail_count++;
            $error("dec_valid high right after reset");
        end

    // Accepted record shows up one cycle later
    a_strobe: assert property (@(posedge clk) disable iff (rst) sched_valid |=> dec_valid)
        else begin
            fail_count++;
            $error("no output record the cycle after a fetch transfer");
        end

endmodule

bind decode_stage decode_assertions u_decode_assertions (
    .clk(clk), .rst(rst), .dec_valid(dec_valid),
    .dec_data(dec_data), .dec_ready(dec_ready), .sched_valid(sched_valid)
);

// File: test/tb_decode_stage.sv
/*
 * Testbench for decode_stage: random instruction stream, reference
 * decoder, scoreboard on the output handshake and final report
 */
module tb_decode_stage;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_instr   = 3000;
    localparam int cycle_limit = num_instr * 6 + 2000;

    logic clk = 1'b0;
    logic rst;
    logic fetch_valid;
    decode_pkg::fetch_t fetch_data;
    logic fetch_ready;
    logic dec_valid;
    decode_pkg::decoded_t dec_data;
    logic dec_ready;
    logic sched_valid;
    logic [decode_pkg::nw_bits-1:0] sched_wid;
    logic sched_stall;

    decode_pkg::decoded_t expected_q[$];
    logic [31:0] rng = 32'hf94d4863;
    int errors = 0;
    int n_in = 0;
    int n_out = 0;
    int n_sent = 0;
    int cycles = 0;

    decode_stage u_decode_stage (
        .clk(clk), .rst(rst),
        .fetch_valid(fetch_valid), .fetch_data(fetch_data), .fetch_ready(fetch_ready),
        .dec_valid(dec_valid), .dec_data(dec_data), .dec_ready(dec_ready),
        .sched_valid(sched_valid), .sched_wid(sched_wid), .sched_stall(sched_stall)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    function automatic logic [3:0] alu_code(input logic [2:0] f3, input logic alt,
                                            input logic is_reg);
        case (f3)
            3'd0: return (is_reg && alt) ? decode_pkg::sub : decode_pkg::add;
            3'd1: return decode_pkg::sll;
            3'd2: return decode_pkg::slt;
            3'd3: return decode_pkg::sltu;
            3'd4: return decode_pkg::xor_op;
            3'd5: return alt ? decode_pkg::sra : decode_pkg::srl;
            3'd6: return decode_pkg::or_op;
            default: return decode_pkg::and_op;
        endcase
    endfunction

    function automatic logic [3:0] mul_code(input logic [2:0] f3);
        case (f3)
            3'd0: return decode_pkg::mul;
            3'd1: return decode_pkg::mulh;
            3'd2: return decode_pkg::mulhsu;
            3'd3: return decode_pkg::mulhu;
            3'd4: return decode_pkg::div;
            3'd5: return decode_pkg::divu;
            3'd6: return decode_pkg::rem;
            default: return decode_pkg::remu;
        endcase
    endfunction

    function automatic logic [3:0] branch_code(input logic [2:0] f3);
        case (f3)
            3'd0: return decode_pkg::eq;
            3'd1: return decode_pkg::ne;
            3'd4: return decode_pkg::lt;
            3'd5: return decode_pkg::ge;
            3'd6: return decode_pkg::ltu;
            3'd7: return decode_pkg::geu;
            default: return 4'd0;
        endcase
    endfunction

    function automatic logic [3:0] env_code(input logic [11:0] field);
        case (field)
            12'h000: return decode_pkg::ecall;
            12'h001: return decode_pkg::ebreak;
            12'h002: return decode_pkg::uret;
            12'h102: return decode_pkg::sret;
            12'h302: return decode_pkg::mret;
            default: return 4'd0;
        endcase
    endfunction

    function automatic decode_pkg::decoded_t ref_decode(input decode_pkg::fetch_t f,
                                                        output logic stall);
        decode_pkg::decoded_t d;
        logic [31:0] w;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [31:0] imm_i;
        logic writes;
        w = f.instr;
        f3 = w[14:12];
        f7 = w[31:25];
        imm_i = {{20{w[31]}}, w[31:20]};
        d = '0;
        stall = 1'b0;
        writes = 1'b0;
        d.wid = f.wid;
        d.tmask = f.tmask;
        d.pc = f.pc;
        case (w[6:0])
            decode_pkg::op_imm: begin
                d.op_type = alu_code(f3, f7[5], 1'b0);
                d.imm = (f3 == 3'd1 || f3 == 3'd5) ? {27'd0, w[24:20]} : imm_i;   // Shamt
                {writes, d.use_imm, d.rd, d.rs1} = {2'b11, w[11:7], w[19:15]};
            end
            decode_pkg::op: begin
                if (f7 == 7'h01) begin
                    d.op_type = mul_code(f3);
                    d.op_mod = 3'b010;
                end else begin
                    d.op_type = alu_code(f3, f7[5], 1'b1);
                end
                {writes, d.rd, d.rs1, d.rs2} = {1'b1, w[11:7], w[19:15], w[24:20]};
            end
            decode_pkg::lui, decode_pkg::auipc: begin
                d.use_pc = (w[6:0] == decode_pkg::auipc);
                d.op_type = d.use_pc ? decode_pkg::auipc_op : decode_pkg::lui_op;
                {writes, d.use_imm, d.rd, d.imm} = {2'b11, w[11:7], w[31:12], 12'd0};
            end
            decode_pkg::jal: begin
                d.op_type = decode_pkg::jal_op;
                {stall, writes, d.use_imm, d.use_pc, d.op_mod} = {4'b1111, 3'b001};
                d.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                d.rd = w[11:7];
            end
            decode_pkg::jalr: begin
                d.op_type = decode_pkg::jalr_op;
                {stall, writes, d.use_imm, d.op_mod, d.imm} = {3'b111, 3'b001, imm_i};
                {d.rd, d.rs1} = {w[11:7], w[19:15]};
            end
            decode_pkg::branch: begin
                d.op_type = branch_code(f3);
                {stall, d.use_imm, d.use_pc, d.op_mod} = {3'b111, 3'b001};
                d.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                {d.rs1, d.rs2} = {w[19:15], w[24:20]};
            end
            decode_pkg::load: begin
                d.ex_type = decode_pkg::lsu;
                {d.op_type, writes, d.use_imm, d.imm} = {1'b0, f3, 2'b11, imm_i};
                {d.rd, d.rs1} = {w[11:7], w[19:15]};
            end
            decode_pkg::store: begin
                d.ex_type = decode_pkg::lsu;
                {d.op_type, d.use_imm} = {1'b1, f3, 1'b1};
                d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
                {d.rs1, d.rs2} = {w[19:15], w[24:20]};
            end
            decode_pkg::fence: begin
                d.ex_type = decode_pkg::lsu;
                d.op_type = decode_pkg::lsu_fence;
            end
            decode_pkg::system: begin
                {stall, writes, d.rd} = {2'b11, w[11:7]};
                if (f3[1:0] != 2'b00) begin
                    d.ex_type = decode_pkg::sfu;
                    case (f3[1:0])
                        2'd1: d.op_type = decode_pkg::csrrw;
                        2'd2: d.op_type = decode_pkg::csrrs;
                        default: d.op_type = decode_pkg::csrrc;
                    endcase
                    d.use_imm = f3[2];
                    d.imm = {15'd0, f3[2] ? w[19:15] : 5'd0, w[31:20]};
                    d.rs1 = f3[2] ? 5'd0 : w[19:15];
                end else begin
                    d.op_type = env_code(w[31:20]);
                    {d.use_pc, d.use_imm, d.op_mod, d.imm} = {2'b11, 3'b001, 32'd4};
                end
            end
            decode_pkg::ext1: begin
                if (f7 == 7'h00) begin
                    d.ex_type = decode_pkg::sfu;
                    stall = 1'b1;
                    d.rs1 = (f3 <= 3'd5) ? w[19:15] : 5'd0;
                    case (f3)
                        3'd0: d.op_type = decode_pkg::tmc;
                        3'd1: {d.op_type, d.rs2} = {decode_pkg::wspawn, w[24:20]};
                        3'd2: {d.op_type, writes, d.rd} = {decode_pkg::split, 1'b1, w[11:7]};
                        3'd3: d.op_type = decode_pkg::join_op;
                        3'd4: {d.op_type, d.rs2} = {decode_pkg::bar, w[24:20]};
                        3'd5: {d.op_type, d.rs2} = {decode_pkg::pred, w[24:20]};
                        default: ;
                    endcase
                end
            end
            default: ;
        endcase
        d.wb = writes && (d.rd != 5'd0);
        return d;
    endfunction

    function automatic decode_pkg::fetch_t make_fetch();
        decode_pkg::fetch_t f;
        logic [31:0] w;
        logic [31:0] r;
        w = next_rand();
        case (next_rand() % 12)
            0: w[6:0] = decode_pkg::op_imm;
            1: w[6:0] = decode_pkg::op;
            2: w[6:0] = decode_pkg::lui;
            3: w[6:0] = decode_pkg::auipc;
            4: w[6:0] = decode_pkg::jal;
            5: w[6:0] = decode_pkg::jalr;
            6: w[6:0] = decode_pkg::branch;
            7: w[6:0] = decode_pkg::load;
            8: w[6:0] = decode_pkg::store;
            9: w[6:0] = decode_pkg::fence;
            10: w[6:0] = decode_pkg::system;
            default: w[6:0] = decode_pkg::ext1;
        endcase
        r = next_rand();
        if (w[6:0] == decode_pkg::op) begin
            w[31:25] = (r[1:0] == 2'd0) ? 7'h20 : (r[1:0] == 2'd1) ? 7'h01 : 7'h00;
        end
        if (w[6:0] == decode_pkg::op_imm && w[12]) begin
            w[31:25] = {1'b0, w[30], 5'd0};   // SLLI, SRLI, SRAI
        end
        if (w[6:0] == decode_pkg::system && r[2]) begin
            w[19:7] = '0;
            case (r[5:3] % 5)
                0: w[31:20] = 12'h000;
                1: w[31:20] = 12'h001;
                2: w[31:20] = 12'h002;
                3: w[31:20] = 12'h102;
                default: w[31:20] = 12'h302;
            endcase
        end
        if (w[6:0] == decode_pkg::ext1 && r[8:6] != 3'd0) w[31:25] = 7'h00;
        if (r[11:9] == 3'd0) w[11:7] = 5'd0;   // Extra x0 destinations
        r = next_rand();
        f.instr = w;
        f.wid = r[1:0];
        f.tmask = r[5:2];
        f.pc = {next_rand() & 32'hffff_fffc};
        return f;
    endfunction

    // Sampled mid-cycle where all signals are settled
    always @(negedge clk) begin
        decode_pkg::decoded_t exp_rec;
        logic exp_stall;
        logic exp_ready;
        logic xfer;
        if (!rst) begin
            exp_ready = (expected_q.size() == 0) || dec_ready;
            check("dec_valid", dec_valid, expected_q.size() != 0);
            check("fetch_ready", fetch_ready, exp_ready);
            if (dec_valid && dec_ready) begin
                n_out++;
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("Output record at %0t with no input record pending", $time);
                end else begin
                    exp_rec = expected_q.pop_front();
                    check("dec_data", dec_data, exp_rec);
                end
            end
            xfer = fetch_valid && exp_ready;
            check("sched_valid", sched_valid, xfer);
            if (xfer) begin
                exp_rec = ref_decode(fetch_data, exp_stall);
                check("sched_stall", sched_stall, exp_stall);
                check("sched_wid", sched_wid, fetch_data.wid);
                expected_q.push_back(exp_rec);
                n_in++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles with %0d of %0d records out",
                     cycles, n_out, num_instr);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        logic took;
        rst = 1'b1;
        fetch_valid = 1'b0;
        fetch_data = '0;
        dec_ready = 1'b1;
        repeat (3) @(posedge clk);
        #2 rst = 1'b0;
        while (n_sent < num_instr) begin
            @(negedge clk);
            took = fetch_valid && fetch_ready;
            @(posedge clk);
            #2;
            if (took) n_sent++;
            if (took || !fetch_valid) begin   // Hold until accepted
                fetch_valid = (n_sent < num_instr) && (next_rand() % 4 != 0);
                if (fetch_valid) fetch_data = make_fetch();
            end
            dec_ready = (next_rand() % 4) != 0;
        end
        while (n_out < num_instr) begin
            @(posedge clk);
            #2 dec_ready = (next_rand() % 4) != 0;
        end
        repeat (2) @(posedge clk);
        check("output_count", n_out, n_in);
        check("input_count", n_in, num_instr);
        errors += u_decode_stage.u_decode_assertions.fail_count;
        $display("Records in %0d, out %0d, errors %0d", n_in, n_out, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: compile.f
hdl/decode_pkg.sv
hdl/imm_gen.sv
hdl/func_decode.sv
hdl/instr_decode.sv
hdl/decode_buffer.sv
hdl/decode_stage.sv
test/decode_assertions.sv
test/tb_decode_stage.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - files:
      - hdl/decode_pkg.sv
      - hdl/imm_gen.sv
      - hdl/func_decode.sv
      - hdl/instr_decode.sv
      - hdl/decode_buffer.sv
      - hdl/decode_stage.sv
  - target: test
    files:
      - test/decode_assertions.sv
      - test/tb_decode_stage.sv
